// File: verilog/psram_pkg.sv
package psram_pkg;

    localparam int addr_w = 23;
    localparam int data_w = 64;
    localparam int sel_w = 8;
    localparam int mem_w = 16;
    localparam int beats = 4;

    // bus configuration register, msb first
    typedef struct packed {
        logic [2:0] rsvd_hi;
        logic [1:0] reg_sel;
        logic [1:0] rsvd_a;
        logic       op_mode;
        logic       init_lat;
        logic [2:0] lat_code;
        logic       wait_pol;
        logic       rsvd_b;
        logic       wait_cfg;
        logic [1:0] rsvd_c;
        logic [1:0] drive;
        logic       wrap;
        logic [2:0] burst_len;
    } bcr_t;

    // same address pins carry the BCR value on a cre cycle
    typedef union packed {
        logic [addr_w-1:0] linear;
        bcr_t              bcr;
    } mem_addr_u;

    // sync burst, variable latency 3, wait active high, 4 words
    localparam bcr_t bcr_default = '{
        rsvd_hi: 3'b000, reg_sel: 2'b10, rsvd_a: 2'b00,
        op_mode: 1'b0, init_lat: 1'b0, lat_code: 3'd3,
        wait_pol: 1'b1, rsvd_b: 1'b0, wait_cfg: 1'b1,
        rsvd_c: 2'b00, drive: 2'b01, wrap: 1'b1, burst_len: 3'b001
    };

endpackage

// File: verilog/psram_mem_if.sv
`timescale 1ns/1ps

interface psram_mem_if;

    logic                        clk_en;
    logic                        cen_n;
    logic                        adv_n;
    logic                        oen_n;
    logic                        wen_n;
    logic                        cre;
    logic [1:0]                  be_n;
    logic [psram_pkg::addr_w-1:0] addr;
    logic [psram_pkg::mem_w-1:0]  dout;
    logic                        dout_oe;
    logic [psram_pkg::mem_w-1:0]  din;
    logic                        wait_in;

    modport seq (
        output clk_en, cen_n, adv_n, oen_n, wen_n, cre, be_n, addr, dout, dout_oe,
        input  din, wait_in
    );

    modport pins (
        input  clk_en, cen_n, adv_n, oen_n, wen_n, cre, be_n, addr, dout, dout_oe,
        output din, wait_in
    );

endinterface

// File: verilog/psram_init.sv
`timescale 1ns/1ps

module psram_init #(
    parameter int startup_cycles = 15000,
    parameter int bcr_we_cycles = 6
) (
    input  logic clk,
    input  logic rst_n,
    output logic init_done,
    psram_mem_if.seq mem
);

    localparam int cnt_max = (startup_cycles > bcr_we_cycles) ? startup_cycles : bcr_we_cycles;
    localparam int cnt_w = $clog2(cnt_max) + 1;

    localparam logic [2:0] st_wait = 3'd0;
    localparam logic [2:0] st_addr1 = 3'd1;
    localparam logic [2:0] st_addr2 = 3'd2;
    localparam logic [2:0] st_we = 3'd3;
    localparam logic [2:0] st_done = 3'd4;

    logic [2:0]           state_q;
    logic [cnt_w-1:0]     cnt_q;
    psram_pkg::mem_addr_u bcr_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_wait;
            cnt_q <= cnt_w'(startup_cycles - 1);
        end else begin
            case (state_q)
                st_wait: begin
                    if (cnt_q == '0)
                        state_q <= st_addr1;
                    else
                        cnt_q <= cnt_q - 1'b1;
                end
                st_addr1: state_q <= st_addr2;
                st_addr2: begin
                    state_q <= st_we;
                    cnt_q <= cnt_w'(bcr_we_cycles - 1);
                end
                st_we: begin
                    if (cnt_q == '0)
                        state_q <= st_done;
                    else
                        cnt_q <= cnt_q - 1'b1;
                end
                st_done: state_q <= st_done;
                default: state_q <= st_wait;
            endcase
        end
    end

    assign bcr_word.bcr = psram_pkg::bcr_default;

    // asynchronous config write, memory clock stays off
    assign mem.clk_en = 1'b0;
    assign mem.addr = bcr_word.linear;
    assign mem.cre = (state_q == st_addr1) || (state_q == st_addr2);
    assign mem.adv_n = (state_q != st_addr1);
    assign mem.cen_n = !(mem.cre || state_q == st_we);
    assign mem.wen_n = (state_q != st_we);
    assign mem.oen_n = 1'b1;
    assign mem.be_n = 2'b00;
    assign mem.dout = '0;
    assign mem.dout_oe = 1'b0;

    assign init_done = (state_q == st_done);

endmodule

// File: verilog/psram_ctrlr.sv
`timescale 1ns/1ps

module psram_ctrlr #(
    parameter int startup_cycles = 15000,
    parameter int bcr_we_cycles = 6
) (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         controller_ready,
    input  logic [psram_pkg::addr_w-1:0] fml_adr,
    input  logic                         fml_stb,
    input  logic                         fml_we,
    input  logic [psram_pkg::sel_w-1:0]  fml_sel,
    input  logic [psram_pkg::data_w-1:0] fml_di,
    output logic [psram_pkg::data_w-1:0] fml_do,
    output logic                         fml_eack,
    psram_mem_if.seq                     mem
);

    localparam int lane_w = psram_pkg::mem_w / 8;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_write = 2'd1;
    localparam logic [1:0] st_read = 2'd2;

    // cycle numbers counted from the accepting edge
    localparam logic [3:0] wr_last = 4'd11;
    localparam logic [3:0] wr_first = wr_last - 4'(psram_pkg::beats) + 4'd1;
    localparam logic [3:0] rd_oe = 4'd7;
    localparam logic [3:0] rd_last = 4'd12;
    localparam logic [3:0] rd_first = rd_last - 4'(psram_pkg::beats) + 4'd1;

    logic [1:0]                         state_q;
    logic [3:0]                         cyc_q;
    psram_pkg::mem_addr_u               addr_q;
    logic [psram_pkg::data_w-1:0]       dat_q;
    logic [psram_pkg::sel_w-1:0]        be_q;
    logic                               init_done;
    logic                               accept;
    logic                               last_cyc;
    logic [3:0]                         beat_off;
    logic [$clog2(psram_pkg::beats)-1:0] beat;

    logic                        seq_clk_en;
    logic                        seq_cen_n;
    logic                        seq_adv_n;
    logic                        seq_oen_n;
    logic                        seq_wen_n;
    logic [1:0]                  seq_be_n;
    logic [psram_pkg::mem_w-1:0] seq_dout;
    logic                        seq_dout_oe;

    psram_mem_if init_bus ();

    psram_init #(
        .startup_cycles(startup_cycles),
        .bcr_we_cycles(bcr_we_cycles)
    ) u_init (
        .clk(clk),
        .rst_n(rst_n),
        .init_done(init_done),
        .mem(init_bus.seq)
    );

    assign init_bus.din = mem.din;
    assign init_bus.wait_in = mem.wait_in;

    assign controller_ready = init_done;
    assign accept = init_done && (state_q == st_idle) && fml_stb;
    assign last_cyc = (state_q == st_write) ? (cyc_q == wr_last) : (cyc_q == rd_last);
    assign beat_off = (state_q == st_read) ? cyc_q - rd_first : cyc_q - wr_first;
    assign beat = beat_off[$clog2(psram_pkg::beats)-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            cyc_q <= 4'd0;
        end else if (accept) begin
            state_q <= fml_we ? st_write : st_read;
            cyc_q <= 4'd1;
        end else if (state_q != st_idle) begin
            if (last_cyc) begin
                state_q <= st_idle;
                cyc_q <= 4'd0;
            end else begin
                cyc_q <= cyc_q + 4'd1;
            end
        end
    end

    // address word holds the BCR value until init is through
    always_ff @(posedge clk) begin
        if (!init_done) begin
            addr_q.linear <= init_bus.addr;
        end else if (accept) begin
            addr_q.linear <= fml_adr;
            dat_q <= fml_di;
            be_q <= ~fml_sel;
        end
        if (state_q == st_read && cyc_q >= rd_first && cyc_q < rd_last)
            dat_q[beat*psram_pkg::mem_w +: psram_pkg::mem_w] <= mem.din;
    end

    // last read beat is taken straight from the pin stage register
    assign fml_do = {mem.din, dat_q[psram_pkg::data_w-psram_pkg::mem_w-1:0]};

    always_comb begin
        seq_clk_en = 1'b0;
        seq_cen_n = 1'b1;
        seq_adv_n = 1'b1;
        seq_oen_n = 1'b1;
        seq_wen_n = 1'b1;
        seq_be_n = 2'b00;
        seq_dout = '0;
        seq_dout_oe = 1'b0;
        fml_eack = 1'b0;
        case (state_q)
            st_write: begin
                seq_clk_en = 1'b1;
                seq_cen_n = 1'b0;
                if (cyc_q == 4'd1) begin
                    seq_adv_n = 1'b0;
                    seq_wen_n = 1'b0;
                end
                if (cyc_q >= wr_first) begin
                    seq_dout_oe = 1'b1;
                    seq_dout = dat_q[beat*psram_pkg::mem_w +: psram_pkg::mem_w];
                    seq_be_n = be_q[beat*lane_w +: lane_w];
                end
                fml_eack = (cyc_q == wr_last);
            end
            st_read: begin
                if (cyc_q < rd_last) begin
                    seq_clk_en = 1'b1;
                    seq_cen_n = 1'b0;
                    seq_adv_n = (cyc_q != 4'd1);
                    seq_oen_n = (cyc_q < rd_oe);
                end
                fml_eack = (cyc_q == rd_last);
            end
            default: ;
        endcase
    end

    // bus goes to the sequencer once init is done
    always_comb begin
        if (init_done) begin
            mem.clk_en = seq_clk_en;
            mem.cen_n = seq_cen_n;
            mem.adv_n = seq_adv_n;
            mem.oen_n = seq_oen_n;
            mem.wen_n = seq_wen_n;
            mem.cre = 1'b0;
            mem.be_n = seq_be_n;
            mem.dout = seq_dout;
            mem.dout_oe = seq_dout_oe;
        end else begin
            mem.clk_en = init_bus.clk_en;
            mem.cen_n = init_bus.cen_n;
            mem.adv_n = init_bus.adv_n;
            mem.oen_n = init_bus.oen_n;
            mem.wen_n = init_bus.wen_n;
            mem.cre = init_bus.cre;
            mem.be_n = init_bus.be_n;
            mem.dout = init_bus.dout;
            mem.dout_oe = init_bus.dout_oe;
        end
    end

    assign mem.addr = addr_q.linear;

endmodule

// File: verilog/psram_phy.sv
`timescale 1ns/1ps

module psram_phy (
    input  logic                         clk,
    input  logic                         rst_n,
    psram_mem_if.pins                    mem,
    output logic                         mem_clk,
    output logic                         mem_cen_n,
    output logic                         mem_adv_n,
    output logic                         mem_oen_n,
    output logic                         mem_wen_n,
    output logic                         mem_cre,
    output logic [1:0]                   mem_be_n,
    output logic [psram_pkg::addr_w-1:0] mem_addr,
    output logic [psram_pkg::mem_w-1:0]  mem_dq_o,
    output logic                         mem_dq_oe,
    input  logic [psram_pkg::mem_w-1:0]  mem_dq_i,
    input  logic                         mem_wait
);

    logic                        clk_en_q;
    logic [psram_pkg::mem_w-1:0] dq_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_en_q <= 1'b0;
            mem_cen_n <= 1'b1;
            mem_adv_n <= 1'b1;
            mem_oen_n <= 1'b1;
            mem_wen_n <= 1'b1;
            mem_cre <= 1'b0;
            mem_dq_oe <= 1'b0;
            mem.wait_in <= 1'b0;
        end else begin
            clk_en_q <= mem.clk_en;
            mem_cen_n <= mem.cen_n;
            mem_adv_n <= mem.adv_n;
            mem_oen_n <= mem.oen_n;
            mem_wen_n <= mem.wen_n;
            mem_cre <= mem.cre;
            mem_dq_oe <= mem.dout_oe;
            mem.wait_in <= mem_wait;
        end
    end

    always_ff @(posedge clk) begin
        mem_be_n <= mem.be_n;
        mem_addr <= mem.addr;
        dq_q <= mem.dout;
        mem.din <= mem_dq_i;
    end

    // memory samples on the falling edge of clk, mid-way through each output cycle
    assign mem_clk = clk_en_q & ~clk;

    assign mem_dq_o = mem_dq_oe ? dq_q : '0;

endmodule

// File: verilog/psram_top.sv
`timescale 1ns/1ps

module psram_top #(
    parameter int startup_cycles = 15000,
    parameter int bcr_we_cycles = 6
) (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         controller_ready,
    input  logic [psram_pkg::addr_w-1:0] fml_adr,
    input  logic                         fml_stb,
    input  logic                         fml_we,
    input  logic [psram_pkg::sel_w-1:0]  fml_sel,
    input  logic [psram_pkg::data_w-1:0] fml_di,
    output logic [psram_pkg::data_w-1:0] fml_do,
    output logic                         fml_eack,
    output logic                         mem_clk,
    output logic                         mem_cen_n,
    output logic                         mem_adv_n,
    output logic                         mem_oen_n,
    output logic                         mem_wen_n,
    output logic                         mem_cre,
    output logic [1:0]                   mem_be_n,
    output logic [psram_pkg::addr_w-1:0] mem_addr,
    output logic [psram_pkg::mem_w-1:0]  mem_dq_o,
    output logic                         mem_dq_oe,
    input  logic [psram_pkg::mem_w-1:0]  mem_dq_i,
    input  logic                         mem_wait
);

    psram_mem_if mem ();

    psram_ctrlr #(
        .startup_cycles(startup_cycles),
        .bcr_we_cycles(bcr_we_cycles)
    ) u_ctrlr (
        .clk(clk),
        .rst_n(rst_n),
        .controller_ready(controller_ready),
        .fml_adr(fml_adr),
        .fml_stb(fml_stb),
        .fml_we(fml_we),
        .fml_sel(fml_sel),
        .fml_di(fml_di),
        .fml_do(fml_do),
        .fml_eack(fml_eack),
        .mem(mem.seq)
    );

    psram_phy u_phy (
        .clk(clk),
        .rst_n(rst_n),
        .mem(mem.pins),
        .mem_clk(mem_clk),
        .mem_cen_n(mem_cen_n),
        .mem_adv_n(mem_adv_n),
        .mem_oen_n(mem_oen_n),
        .mem_wen_n(mem_wen_n),
        .mem_cre(mem_cre),
        .mem_be_n(mem_be_n),
        .mem_addr(mem_addr),
        .mem_dq_o(mem_dq_o),
        .mem_dq_oe(mem_dq_oe),
        .mem_dq_i(mem_dq_i),
        .mem_wait(mem_wait)
    );

endmodule

// File: verif/psram_model.sv
`timescale 1ns/1ps

module psram_model (
    input  logic                         mem_clk,
    input  logic                         mem_cen_n,
    input  logic                         mem_adv_n,
    input  logic                         mem_oen_n,
    input  logic                         mem_wen_n,
    input  logic                         mem_cre,
    input  logic [1:0]                   mem_be_n,
    input  logic [psram_pkg::addr_w-1:0] mem_addr,
    input  logic [psram_pkg::mem_w-1:0]  mem_dq_o,
    input  logic                         mem_dq_oe,
    output logic [psram_pkg::mem_w-1:0]  mem_dq_i,
    output logic                         mem_wait
);

    logic [psram_pkg::mem_w-1:0]  store [logic [psram_pkg::addr_w-1:0]];
    logic [psram_pkg::addr_w-1:0] bcr_q;
    logic [psram_pkg::addr_w-1:0] cfg_addr;
    logic                         cfg_cre;
    logic [psram_pkg::addr_w-1:0] burst_addr;
    logic [psram_pkg::addr_w-1:0] word_addr;
    logic [psram_pkg::mem_w-1:0]  word;
    logic                         burst_rd;
    logic                         burst_on;
    int                           beat;

    // unwritten words return a pattern built from the whole address
    function automatic logic [psram_pkg::mem_w-1:0] read_word(
        input logic [psram_pkg::addr_w-1:0] a
    );
        return store.exists(a) ? store[a] : a[15:0] ^ {9'd0, a[22:16]};
    endfunction

    initial begin
        bcr_q = '0;
        cfg_cre = 1'b0;
        burst_on = 1'b0;
        mem_dq_i = '0;
    end

    assign mem_wait = 1'b0;

    // asynchronous config write, address taken when adv_n rises
    always @(posedge mem_adv_n) begin
        cfg_addr = mem_addr;
        cfg_cre = mem_cre;
    end

    always @(posedge mem_wen_n) begin
        if (cfg_cre === 1'b1) begin
            bcr_q = cfg_addr;
            cfg_cre = 1'b0;
        end
    end

    always @(posedge mem_clk) begin
        word_addr = burst_addr + beat[psram_pkg::addr_w-1:0];
        if (!mem_cen_n && !mem_adv_n) begin
            burst_addr = mem_addr;
            burst_rd = mem_wen_n;
            burst_on = 1'b1;
            beat = 0;
        end else if (burst_on && !burst_rd && mem_dq_oe) begin
            word = read_word(word_addr);
            if (!mem_be_n[0])
                word[7:0] = mem_dq_o[7:0];
            if (!mem_be_n[1])
                word[15:8] = mem_dq_o[15:8];
            store[word_addr] = word;
            beat = beat + 1;
            burst_on = (beat < psram_pkg::beats);
        end else if (burst_on && burst_rd && !mem_oen_n) begin
            // first word goes out on the first clock with oen_n low
            mem_dq_i <= read_word(word_addr);
            beat = beat + 1;
            burst_on = (beat < psram_pkg::beats);
        end
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

// File: verif/psram_assertions.sv
`timescale 1ns/1ps

module psram_assertions (
    input logic clk,
    input logic rst_n,
    input logic mem_cen_n,
    input logic mem_oen_n,
    input logic mem_wen_n,
    input logic mem_cre,
    input logic mem_dq_oe
);

    int fail_count = 0;

    // controller and memory never drive dq at the same time
    no_contention: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_dq_oe && !mem_oen_n))
        else begin
            fail_count++;
            $error("data bus driven while oen_n is low");
        end

    cre_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_cre |-> !mem_cen_n)
        else begin
            fail_count++;
            $error("cre high outside a chip-enabled cycle");
        end

    no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(!mem_wen_n && !mem_oen_n))
        else begin
            fail_count++;
            $error("wen_n and oen_n low together");
        end

endmodule

bind psram_phy psram_assertions u_pin_check (
    .clk(clk),
    .rst_n(rst_n),
    .mem_cen_n(mem_cen_n),
    .mem_oen_n(mem_oen_n),
    .mem_wen_n(mem_wen_n),
    .mem_cre(mem_cre),
    .mem_dq_oe(mem_dq_oe)
);

// File: verif/psram_tb.sv
`timescale 1ns/1ps

module psram_tb;

    localparam int startup_cycles = 20;
    localparam int bcr_we_cycles = 6;
    localparam int n_ops = 12;
    localparam int startup_len = startup_cycles + 2 + bcr_we_cycles;
    localparam int cycle_limit = 40 + n_ops * 20 + startup_len;

    typedef struct packed {
        logic                         we;
        logic [psram_pkg::sel_w-1:0]  sel;
        logic [psram_pkg::addr_w-1:0] adr;
        logic [3:0]                   lat;
    } op_t;

    // write flag, byte selects, address, cycles from accept to eack
    op_t ops [n_ops] = '{
        '{1'b1, 8'hff, 23'h000010, 4'd11},
        '{1'b0, 8'hff, 23'h000010, 4'd12},
        '{1'b1, 8'haa, 23'h000010, 4'd11},
        '{1'b0, 8'hff, 23'h000010, 4'd12},
        '{1'b1, 8'hff, 23'h7ffff8, 4'd11},
        '{1'b1, 8'hff, 23'h012344, 4'd11},
        '{1'b1, 8'h0f, 23'h7ffff8, 4'd11},
        '{1'b1, 8'h3c, 23'h012344, 4'd11},
        '{1'b0, 8'hff, 23'h7ffff8, 4'd12},
        '{1'b0, 8'hff, 23'h012344, 4'd12},
        '{1'b1, 8'h81, 23'h000010, 4'd11},
        '{1'b0, 8'hff, 23'h000010, 4'd12}
    };

    logic                         clk;
    logic                         rst_n;
    logic                         controller_ready;
    logic [psram_pkg::addr_w-1:0] fml_adr;
    logic                         fml_stb;
    logic                         fml_we;
    logic [psram_pkg::sel_w-1:0]  fml_sel;
    logic [psram_pkg::data_w-1:0] fml_di;
    logic [psram_pkg::data_w-1:0] fml_do;
    logic                         fml_eack;
    logic                         mem_clk;
    logic                         mem_cen_n;
    logic                         mem_adv_n;
    logic                         mem_oen_n;
    logic                         mem_wen_n;
    logic                         mem_cre;
    logic [1:0]                   mem_be_n;
    logic [psram_pkg::addr_w-1:0] mem_addr;
    logic [psram_pkg::mem_w-1:0]  mem_dq_o;
    logic                         mem_dq_oe;
    logic [psram_pkg::mem_w-1:0]  mem_dq_i;
    logic                         mem_wait;

    logic [psram_pkg::data_w-1:0] ref_mem [logic [psram_pkg::addr_w-1:0]];
    logic [31:0]                  lcg_state = 32'd18057;
    psram_pkg::mem_addr_u         captured;
    int                           cycles = 0;
    int                           waited;

    tb_clock #(.period(100)) u_clock (.clk(clk));

    psram_top #(
        .startup_cycles(startup_cycles),
        .bcr_we_cycles(bcr_we_cycles)
    ) UUT (
        .clk(clk),
        .rst_n(rst_n),
        .controller_ready(controller_ready),
        .fml_adr(fml_adr),
        .fml_stb(fml_stb),
        .fml_we(fml_we),
        .fml_sel(fml_sel),
        .fml_di(fml_di),
        .fml_do(fml_do),
        .fml_eack(fml_eack),
        .mem_clk(mem_clk),
        .mem_cen_n(mem_cen_n),
        .mem_adv_n(mem_adv_n),
        .mem_oen_n(mem_oen_n),
        .mem_wen_n(mem_wen_n),
        .mem_cre(mem_cre),
        .mem_be_n(mem_be_n),
        .mem_addr(mem_addr),
        .mem_dq_o(mem_dq_o),
        .mem_dq_oe(mem_dq_oe),
        .mem_dq_i(mem_dq_i),
        .mem_wait(mem_wait)
    );

    psram_model u_model (
        .mem_clk(mem_clk),
        .mem_cen_n(mem_cen_n),
        .mem_adv_n(mem_adv_n),
        .mem_oen_n(mem_oen_n),
        .mem_wen_n(mem_wen_n),
        .mem_cre(mem_cre),
        .mem_be_n(mem_be_n),
        .mem_addr(mem_addr),
        .mem_dq_o(mem_dq_o),
        .mem_dq_oe(mem_dq_oe),
        .mem_dq_i(mem_dq_i),
        .mem_wait(mem_wait)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] want,
                               input string what);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // one FML request, entered and left on a falling edge
    task automatic run_op(input op_t op);
        logic [psram_pkg::data_w-1:0] data;
        logic [psram_pkg::data_w-1:0] want;
        int                           n;
        data = {next_random(), next_random()};
        want = ref_mem[op.adr];
        if (op.we) begin
            for (int b = 0; b < psram_pkg::sel_w; b++)
                if (op.sel[b])
                    want[8*b +: 8] = data[8*b +: 8];
            ref_mem[op.adr] = want;
        end
        fml_adr = op.adr;
        fml_we = op.we;
        fml_sel = op.sel;
        fml_di = data;
        fml_stb = 1'b1;
        n = 0;
        while (fml_eack !== 1'b1) begin
            @(negedge clk);
            n++;
        end
        check_equal(64'(n), 64'(op.lat), "acknowledge latency");
        if (!op.we)
            check_equal(fml_do, want, "read data");
        fml_stb = 1'b0;
        @(negedge clk);
        check_equal(64'(fml_eack), 64'(0), "acknowledge longer than one cycle");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the controller stopped answering", cycles);
            $display("Test failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (UUT.u_phy.u_pin_check.fail_count != 0) begin
            $display("A protocol assertion on the memory pins failed");
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        rst_n = 1'b0;
        fml_adr = '0;
        fml_stb = 1'b0;
        fml_we = 1'b0;
        fml_sel = '0;
        fml_di = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        // ready stays low through power-up wait and BCR write
        waited = 0;
        while (controller_ready !== 1'b1) begin
            @(negedge clk);
            waited++;
        end
        check_equal(64'(waited), 64'(startup_len), "cycles until controller ready");
        // wen_n reaches the pins one cycle after ready
        @(negedge clk);
        captured.linear = u_model.bcr_q;
        check_equal(64'(captured.bcr), 64'(psram_pkg::bcr_default), "BCR in the memory");
        for (int i = 0; i < n_ops; i++)
            run_op(ops[i]);
        $display("Test passed");
        $finish;
    end

endmodule

// File: vlog.f
verilog/psram_pkg.sv
verilog/psram_mem_if.sv
verilog/psram_init.sv
verilog/psram_ctrlr.sv
verilog/psram_phy.sv
verilog/psram_top.sv
verif/psram_model.sv
verif/tb_clock.sv
verif/psram_assertions.sv
verif/psram_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = psram_tb
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
